// File: design/attn_out_pkg.sv
// Attention output path
// Shared sizes and bus types
package attn_out_pkg;

    // Number of PEs and also the number of rows held in one bank
    // The bank row index wraps on its own, so this has to be a power of two
    localparam int NUM_PES = 4;

    // Elements per O vector and the width of each element
    localparam int VEC_LEN = 4;
    localparam int ELEM_W  = 8;

    // Accepted steps that make up one tile
    localparam int SEQ_LEN = 4;

    // Memory row address width that wraps addresses after 64 rows
    localparam int ADDR_W = 6;

    // Derived index widths for the bank row and the step count
    localparam int ROW_W  = $clog2(NUM_PES);
    localparam int STEP_W = $clog2(SEQ_LEN);

    typedef logic [ELEM_W-1:0] elem_t;

    // Value vector, O vector and memory data all share this layout
    typedef struct packed {
        elem_t [VEC_LEN-1:0] e;
    } o_vector_t;

    // One weight per PE with the weight for PE 0 in the low byte
    typedef struct packed {
        elem_t [NUM_PES-1:0] w;
    } weight_set_t;

    // A whole tile of O vectors with PE 0 in row 0
    typedef struct packed {
        o_vector_t [NUM_PES-1:0] row;
    } o_bank_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        o_vector_t         data;
    } mem_write_t;

endpackage

// File: design/o_vector_pe.sv
// O-vector processing element
`timescale 1ns/1ns

module o_vector_pe (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     step,
    input  logic                     clear,
    input  attn_out_pkg::elem_t      weight,
    input  attn_out_pkg::o_vector_t  v,
    output attn_out_pkg::o_vector_t  o
);

    // Running sum of weight times value vector for the current tile
    attn_out_pkg::o_vector_t acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Start the first tile from zero
            acc <= '0;
        end else if (clear) begin
            // Clear wins over a step in the same cycle
            acc <= '0;
        end else if (step) begin
            for (int i = 0; i < attn_out_pkg::VEC_LEN; i++) begin
                // Product and sum are both truncated to the element width
                acc.e[i] <= acc.e[i] + attn_out_pkg::elem_t'(weight * v.e[i]);
            end
        end
    end

    // The accumulator doubles as the held result once the tile is done
    assign o = acc;

endmodule

// File: design/pe_row.sv
// Row of O-vector PEs
// Counts steps per tile and offers the finished tile to the buffer
`timescale 1ns/1ns

module pe_row (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       step_valid,
    output logic                       step_ready,
    input  attn_out_pkg::o_vector_t    step_v,
    input  attn_out_pkg::weight_set_t  step_w,
    output logic                       write_enable,
    input  logic                       sram_ready,
    output attn_out_pkg::o_bank_t      write_data
);

    // Accepted steps so far in the current tile
    logic [attn_out_pkg::STEP_W-1:0] step_cnt;

    logic step_accept;
    logic last_step;
    logic bank_accept;

    // Per-PE results before they are packed into the bank word
    attn_out_pkg::o_vector_t pe_o [attn_out_pkg::NUM_PES];

    // Steps are refused while a finished tile is still waiting for the buffer
    assign step_ready  = !write_enable;
    assign step_accept = step_valid && step_ready;
    assign last_step   = step_cnt == attn_out_pkg::STEP_W'(attn_out_pkg::SEQ_LEN - 1);

    // The buffer takes the whole tile at this edge, which also clears the PEs
    assign bank_accept = write_enable && sram_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            step_cnt     <= '0;
            write_enable <= 1'b0;
        end else begin
            if (step_accept) begin
                // Counter restarts at zero after the last step of a tile
                step_cnt <= last_step ? '0 : step_cnt + 1'b1;
            end
            if (step_accept && last_step) begin
                write_enable <= 1'b1;
            end else if (bank_accept) begin
                write_enable <= 1'b0;
            end
        end
    end

    // Every PE sees the same value vector but takes its own weight
    for (genvar g = 0; g < attn_out_pkg::NUM_PES; g++) begin : g_pe
        o_vector_pe pe_i (
            .clk    (clk),
            .rst    (rst),
            .step   (step_accept),
            .clear  (bank_accept),
            .weight (step_w.w[g]),
            .v      (step_v),
            .o      (pe_o[g])
        );
    end

    // PE i goes to row i of the bank
    always_comb begin
        for (int i = 0; i < attn_out_pkg::NUM_PES; i++) begin
            write_data.row[i] = pe_o[i];
        end
    end

endmodule

// File: design/o_sram.sv
// Ping-pong O-vector buffer
// Filled one bank at a time and drained one row at a time
`timescale 1ns/1ns

module o_sram (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       write_enable,
    input  logic                       drain_enable,
    output logic                       drain_data_valid,
    output logic                       sram_ready,
    input  attn_out_pkg::o_bank_t      write_data,
    output attn_out_pkg::o_vector_t    drain_data
);

    // Two banks that each hold a full tile of O vectors
    attn_out_pkg::o_bank_t bank [2];

    // Bank that takes the next tile
    logic fill_bank;

    // Bank that rows are currently read from
    logic drain_bank;

    // One empty flag per bank, indexed by bank number
    logic [1:0] bank_empty;

    // Next row to leave the drain bank
    logic [attn_out_pkg::ROW_W-1:0] drain_idx;

    logic bank_write;
    logic row_drain;
    logic last_row;

    // The fill side only takes a tile when its target bank is free
    assign sram_ready = bank_empty[fill_bank];

    // Rows are available as long as the drain bank still holds data
    assign drain_data_valid = !bank_empty[drain_bank];

    // Current row straight out of the drain bank
    assign drain_data = bank[drain_bank].row[drain_idx];

    assign bank_write = write_enable && sram_ready;
    assign row_drain  = drain_enable && drain_data_valid;
    assign last_row   = drain_idx == attn_out_pkg::ROW_W'(attn_out_pkg::NUM_PES - 1);

    // A tile write replaces the whole fill bank in one edge
    always_ff @(posedge clk) begin
        if (bank_write) begin
            bank[fill_bank] <= write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_bank  <= 1'b0;
            drain_bank <= 1'b0;
            bank_empty <= 2'b11;
            drain_idx  <= '0;
        end else begin
            // A whole tile lands at once and the fill side moves on
            if (bank_write) begin
                bank_empty[fill_bank] <= 1'b0;
                fill_bank             <= !fill_bank;
            end

            // Fill and drain never touch the same bank in one cycle
            // because the fill bank is empty while the drain bank is not
            if (row_drain) begin
                // Row index wraps to zero by itself after the last row
                drain_idx <= drain_idx + 1'b1;
                if (last_row) begin
                    bank_empty[drain_bank] <= 1'b1;
                    drain_bank             <= !drain_bank;
                end
            end
        end
    end

endmodule

// File: design/o_writeback.sv
// Memory write-back stage
`timescale 1ns/1ns

module o_writeback (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        drain_data_valid,
    input  attn_out_pkg::o_vector_t     drain_data,
    output logic                        drain_enable,
    input  logic                        mem_ready,
    output logic                        mem_wr_valid,
    output attn_out_pkg::mem_write_t    mem_wr
);

    // Address given to the next captured row
    logic [attn_out_pkg::ADDR_W-1:0] row_addr;

    logic capture;

    // Ask for a row only when the output register is free by the next edge
    assign drain_enable = !mem_wr_valid || mem_ready;
    assign capture      = drain_enable && drain_data_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wr_valid <= 1'b0;
            row_addr     <= '0;
        end else if (capture) begin
            mem_wr_valid <= 1'b1;
            // Address wraps after the last memory row
            row_addr     <= row_addr + 1'b1;
        end else if (mem_ready) begin
            mem_wr_valid <= 1'b0;
        end
    end

    // Payload only changes on capture, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (capture) begin
            mem_wr.addr <= row_addr;
            mem_wr.data <= drain_data;
        end
    end

endmodule

// File: design/attn_out_top.sv
// Attention output path top level
`timescale 1ns/1ns

module attn_out_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       step_valid,
    output logic                       step_ready,
    input  attn_out_pkg::o_vector_t    step_v,
    input  attn_out_pkg::weight_set_t  step_w,
    input  logic                       mem_ready,
    output logic                       mem_wr_valid,
    output attn_out_pkg::mem_write_t   mem_wr
);

    // PE row to buffer
    logic                  write_enable;
    logic                  sram_ready;
    attn_out_pkg::o_bank_t write_data;

    // Buffer to write-back
    logic                    drain_enable;
    logic                    drain_data_valid;
    attn_out_pkg::o_vector_t drain_data;

    pe_row pe_row_i (
        .clk          (clk),
        .rst          (rst),
        .step_valid   (step_valid),
        .step_ready   (step_ready),
        .step_v       (step_v),
        .step_w       (step_w),
        .write_enable (write_enable),
        .sram_ready   (sram_ready),
        .write_data   (write_data)
    );

    // Holds up to two finished tiles while memory stalls
    o_sram o_sram_i (
        .clk              (clk),
        .rst              (rst),
        .write_enable     (write_enable),
        .drain_enable     (drain_enable),
        .drain_data_valid (drain_data_valid),
        .sram_ready       (sram_ready),
        .write_data       (write_data),
        .drain_data       (drain_data)
    );

    o_writeback o_writeback_i (
        .clk              (clk),
        .rst              (rst),
        .drain_data_valid (drain_data_valid),
        .drain_data       (drain_data),
        .drain_enable     (drain_enable),
        .mem_ready        (mem_ready),
        .mem_wr_valid     (mem_wr_valid),
        .mem_wr           (mem_wr)
    );

endmodule

// File: tests/attn_out_properties.sv
// Attention output path properties
`timescale 1ns/1ns

module attn_out_properties (
    input logic                     clk,
    input logic                     rst,
    input logic                     step_ready,
    input logic                     write_enable,
    input logic                     sram_ready,
    input attn_out_pkg::o_bank_t    write_data,
    input logic                     mem_ready,
    input logic                     mem_wr_valid,
    input attn_out_pkg::mem_write_t mem_wr
);

    // Number of assertion failures seen so far
    int fail_count = 0;

    // A finished tile waits with its data frozen until the buffer takes it
    a_write_held: assert property (@(posedge clk) disable iff (rst)
        write_enable && !sram_ready |=> write_enable && $stable(write_data))
        else begin
            $error("write_enable dropped or write_data changed before sram_ready");
            fail_count++;
        end

    // Memory payload holds while the write is stalled
    a_mem_held: assert property (@(posedge clk) disable iff (rst)
        mem_wr_valid && !mem_ready |=> mem_wr_valid && $stable(mem_wr))
        else begin
            $error("mem_wr changed or was dropped under back-pressure");
            fail_count++;
        end

    // Steps open up again right after the buffer takes the tile
    a_step_reopen: assert property (@(posedge clk) disable iff (rst)
        write_enable && sram_ready |=> step_ready)
        else begin
            $error("step_ready stayed low after the tile was written to the buffer");
            fail_count++;
        end

endmodule

bind attn_out_top attn_out_properties props_i (
    .clk          (clk),
    .rst          (rst),
    .step_ready   (step_ready),
    .write_enable (write_enable),
    .sram_ready   (sram_ready),
    .write_data   (write_data),
    .mem_ready    (mem_ready),
    .mem_wr_valid (mem_wr_valid),
    .mem_wr       (mem_wr)
);

// File: tests/attn_out_tb.sv
// Attention output path testbench
`timescale 1ns/1ns

module attn_out_tb;

    localparam int CLK_PERIOD = 8;
    localparam int TILES_A = 3;
    localparam int TILES_B = 5;
    localparam int TILES_C = 3;
    localparam int TILES_D = 9;
    localparam int TOTAL_TILES = TILES_A + TILES_B + TILES_C + TILES_D;
    // Generous per-step bound that also covers the long stall phase
    localparam int CYCLES_PER_STEP = 40;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      step_valid;
    logic                      step_ready;
    attn_out_pkg::o_vector_t   step_v;
    attn_out_pkg::weight_set_t step_w;
    logic                      mem_ready;
    logic                      mem_wr_valid;
    attn_out_pkg::mem_write_t  mem_wr;

    // Memory ready mode where 0 is always ready, 1 is random and 2 is stalled
    int ready_mode;
    int mode_now;
    logic [31:0] ready_bits;
    logic [31:0] lfsr_state;

    // Steps of the tile that is being collected
    attn_out_pkg::o_vector_t   [attn_out_pkg::SEQ_LEN-1:0] tile_v;
    attn_out_pkg::weight_set_t [attn_out_pkg::SEQ_LEN-1:0] tile_w;
    attn_out_pkg::o_bank_t     tile_bank;
    int step_idx;

    // Rows still owed by the DUT, oldest first
    attn_out_pkg::o_vector_t exp_q [$];
    attn_out_pkg::o_vector_t exp_row;
    logic [attn_out_pkg::ADDR_W-1:0] exp_addr;
    int  rows_seen;
    bit  wrap_seen;
    int  value_errs;
    int  proto_errs;

    attn_out_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .step_valid   (step_valid),
        .step_ready   (step_ready),
        .step_v       (step_v),
        .step_w       (step_w),
        .mem_ready    (mem_ready),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr       (mem_wr)
    );

    always #(CLK_PERIOD / 2) clk = !clk;

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) s = s ^ 32'h8020_0003;
        return s;
    endfunction

    // One LFSR step for every bit that is taken
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Each PE i sums weight i times every element over the tile's steps
    function automatic attn_out_pkg::o_bank_t expected_bank(
        input attn_out_pkg::o_vector_t   [attn_out_pkg::SEQ_LEN-1:0] vs,
        input attn_out_pkg::weight_set_t [attn_out_pkg::SEQ_LEN-1:0] ws
    );
        attn_out_pkg::o_bank_t res;
        int sum;
        res = '0;
        for (int p = 0; p < attn_out_pkg::NUM_PES; p++) begin
            for (int e = 0; e < attn_out_pkg::VEC_LEN; e++) begin
                sum = 0;
                for (int s = 0; s < attn_out_pkg::SEQ_LEN; s++) begin
                    sum += ws[s].w[p] * vs[s].e[e];
                end
                res.row[p].e[e] = 8'(sum % 256);
            end
        end
        return res;
    endfunction

    // The mode and the random draw are taken at the edge
    // and the new level goes out 1 ns later
    always begin
        @(posedge clk);
        mode_now = ready_mode;
        if (mode_now == 1) draw_bits(2, ready_bits);
        #1;
        case (mode_now)
            0: mem_ready = 1'b1;
            1: mem_ready = ready_bits[1:0] != 2'b00;
            default: mem_ready = 1'b0;
        endcase
    end

    // Records accepted steps and queues the reference rows per tile
    always @(posedge clk) begin
        if (!rst && step_valid && step_ready) begin
            tile_v[step_idx] = step_v;
            tile_w[step_idx] = step_w;
            if (step_idx == attn_out_pkg::SEQ_LEN - 1) begin
                tile_bank = expected_bank(tile_v, tile_w);
                for (int p = 0; p < attn_out_pkg::NUM_PES; p++) begin
                    exp_q.push_back(tile_bank.row[p]);
                end
                step_idx = 0;
            end else begin
                step_idx++;
            end
        end
    end

    // Every completed memory write is checked against the queue head
    always @(posedge clk) begin
        if (!rst && mem_wr_valid && mem_ready) begin
            assert (exp_q.size() != 0) else begin
                proto_errs++;
                $display("Memory write arrived with no row expected");
            end
            if (exp_q.size() != 0) begin
                exp_row = exp_q.pop_front();
                assert (mem_wr.data == exp_row) else begin
                    value_errs++;
                    $display("ERR mem_wr.data expected 0x%h got 0x%h", exp_row, mem_wr.data);
                end
                assert (mem_wr.addr == exp_addr) else begin
                    value_errs++;
                    $display("ERR mem_wr.addr expected 0x%h got 0x%h", exp_addr, mem_wr.addr);
                end
                if (rows_seen > 0 && mem_wr.addr == '0) wrap_seen = 1'b1;
                exp_addr++;
                rows_seen++;
            end
        end
    end

    // Offers one random step, optionally after a random idle gap
    task automatic drive_step(input bit gaps);
        logic [31:0] gap_bits;
        logic [31:0] v_bits;
        logic [31:0] w_bits;
        if (gaps) begin
            draw_bits(2, gap_bits);
            repeat (int'(gap_bits)) begin
                @(posedge clk);
                #1;
            end
        end
        draw_bits(32, v_bits);
        draw_bits(32, w_bits);
        step_valid = 1'b1;
        step_v     = v_bits;
        step_w     = w_bits;
        // step_ready only moves at an edge, so it is steady here
        while (!step_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        step_valid = 1'b0;
    endtask

    task automatic run_tiles(input int tiles, input bit gaps);
        repeat (tiles * attn_out_pkg::SEQ_LEN) drive_step(gaps);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        rst        = 1'b1;
        step_valid = 1'b0;
        step_v     = '0;
        step_w     = '0;
        mem_ready  = 1'b1;
        ready_mode = 0;
        lfsr_state = 32'hd20e;
        step_idx   = 0;
        exp_addr   = '0;
        rows_seen  = 0;
        wrap_seen  = 1'b0;
        value_errs = 0;
        proto_errs = 0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;

        assert (mem_wr_valid == 1'b0) else begin
            value_errs++;
            $display("ERR mem_wr_valid expected 0x0 got 0x%h", mem_wr_valid);
        end
        assert (step_ready == 1'b1) else begin
            value_errs++;
            $display("ERR step_ready expected 0x1 got 0x%h", step_ready);
        end

        // Memory always ready and back-to-back steps
        run_tiles(TILES_A, 1'b0);
        wait_drained();

        // Random memory stalls and random step gaps
        ready_mode = 1;
        run_tiles(TILES_B, 1'b1);
        ready_mode = 0;
        wait_drained();

        // Memory held off so that both banks and the PE row fill up
        ready_mode = 2;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        run_tiles(TILES_C, 1'b0);
        repeat (16) begin
            assert (step_ready == 1'b0) else begin
                value_errs++;
                $display("ERR step_ready expected 0x0 got 0x%h", step_ready);
            end
            @(posedge clk);
            #1;
        end
        ready_mode = 0;
        wait_drained();

        // Enough further rows to carry the address past 63
        ready_mode = 1;
        run_tiles(TILES_D, 1'b1);
        ready_mode = 0;
        wait_drained();

        // A stray extra write after the last expected row still gets seen
        repeat (8) begin
            @(posedge clk);
            #1;
        end

        assert (rows_seen == TOTAL_TILES * attn_out_pkg::NUM_PES) else begin
            proto_errs++;
            $display("Wrong number of rows written, expected %0d and saw %0d",
                     TOTAL_TILES * attn_out_pkg::NUM_PES, rows_seen);
        end
        assert (wrap_seen) else begin
            proto_errs++;
            $display("Row address never wrapped back to zero");
        end
        assert (dut_i.props_i.fail_count == 0) else begin
            proto_errs += dut_i.props_i.fail_count;
            $display("Bound protocol checks failed %0d times", dut_i.props_i.fail_count);
        end

        $display("Error counts: %0d value errors, %0d protocol errors", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Run length bound taken from the number of planned steps
    initial begin
        #((16 + TOTAL_TILES * attn_out_pkg::SEQ_LEN * CYCLES_PER_STEP) * CLK_PERIOD);
        $display("Watchdog expired before all rows were written");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: flist.f
design/attn_out_pkg.sv
design/o_vector_pe.sv
design/pe_row.sv
design/o_sram.sv
design/o_writeback.sv
design/attn_out_top.sv
tests/attn_out_properties.sv
tests/attn_out_tb.sv

// File: Bender.yml
package:
  name: attn_out

sources:
  - files:
      - design/attn_out_pkg.sv
      - design/o_vector_pe.sv
      - design/pe_row.sv
      - design/o_sram.sv
      - design/o_writeback.sv
      - design/attn_out_top.sv
  - target: test
    files:
      - tests/attn_out_properties.sv
      - tests/attn_out_tb.sv
